/* Bender.yml */
package:
  name: mem_subsystem

sources:
  # design
  - files:
      - design/mem_bus_pkg.sv
      - design/core_access_pkg.sv
      - design/word_memory.sv
      - design/mem_interface.sv
      - design/inst_fetch_unit.sv
      - design/load_store_unit.sv
      - design/mem_subsystem_top.sv

  # verification
  - target: test
    files:
      - verification/mem_subsystem_assert.sv
      - verification/mem_subsystem_tb.sv

/* design/core_access_pkg.sv */
package core_access_pkg;

	// core side reuses the bus word and address types
	import mem_bus_pkg::*;

	// low address bits that select a byte lane
	typedef logic [1:0] byte_off_t;

	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} access_size_e;

	// load or store request from the core
	typedef struct packed {
		logic         is_store;
		access_size_e size;
		logic         is_signed;
		addr_t        addr;
		// store data, right aligned
		word_t        data;
	} ls_req_t;

	// delivered instruction with its pc
	typedef struct packed {
		addr_t pc;
		word_t instr;
	} fetch_out_t;

endpackage

/* design/inst_fetch_unit.sv */
module inst_fetch_unit
	import mem_bus_pkg::*;
	import core_access_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       redirect,
	input  addr_t      redirect_pc,
	input  logic       fetch_next,
	output logic       fetch_busy,
	output fetch_out_t fetch_out,
	output logic       instr_valid,
	output logic       inst_start,
	output addr_t      i_addr,
	input  logic       inst_valid,
	input  word_t      inst
);

	addr_t pc;
	logic  busy;
	logic  valid_prev;
	logic  inst_rise;

	// new instruction shows as a rising inst_valid
	assign inst_rise = inst_valid && !valid_prev;

	// requests while busy are dropped
	assign inst_start = fetch_next && !busy;
	assign i_addr     = pc;
	assign fetch_busy = busy;

	// deliver the instruction with its pc
	always_ff @(posedge clk) begin
		if (busy && inst_rise) begin
			fetch_out.pc    <= pc;
			fetch_out.instr <= inst;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			busy        <= 1'b0;
			valid_prev  <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			valid_prev  <= inst_valid;
			instr_valid <= 1'b0;
			if (inst_start) begin
				busy <= 1'b1;
			end else if (redirect && !busy) begin
				// redirect only from idle
				pc <= redirect_pc;
			end
			if (busy && inst_rise) begin
				busy        <= 1'b0;
				instr_valid <= 1'b1;
				// next sequential word
				pc          <= pc + addr_t'(4);
			end
		end
	end

endmodule

/* design/load_store_unit.sv */
module load_store_unit
	import mem_bus_pkg::*;
	import core_access_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     ls_start,
	input  ls_req_t  ls_req,
	output logic     ls_busy,
	output word_t    load_data,
	output logic     ls_done,
	output mem_req_t d_cmd,
	input  logic     d_done,
	input  word_t    rdata
);

	ls_req_t   req_q;
	logic      busy;
	byte_off_t off;
	mask_t     size_mask;
	word_t     lane_data;
	word_t     ext_data;

	assign off     = ls_req.addr[1:0];
	assign ls_busy = busy;

	// lanes covered by the access size
	always_comb begin
		case (ls_req.size)
			BYTE:    size_mask = 32'h0000_00ff;
			HALF:    size_mask = 32'h0000_ffff;
			default: size_mask = '1;
		endcase
	end

	// word command, valid for one cycle from idle
	always_comb begin
		d_cmd.cmd   = NOP;
		d_cmd.addr  = '0;
		d_cmd.wdata = '0;
		d_cmd.wmask = '0;
		if (ls_start && !busy) begin
			d_cmd.cmd   = ls_req.is_store ? WRITE : READ;
			d_cmd.addr  = {ls_req.addr[31:2], 2'b00};
			// shift data and mask into their byte lanes
			d_cmd.wdata = ls_req.data << {off, 3'b000};
			d_cmd.wmask = ls_req.is_store ? (size_mask << {off, 3'b000}) : '0;
		end
	end

	// addressed lanes down to bit 0
	assign lane_data = rdata >> {req_q.addr[1:0], 3'b000};

	always_comb begin
		case (req_q.size)
			BYTE: ext_data = req_q.is_signed ? {{24{lane_data[7]}}, lane_data[7:0]}
			                                 : {24'd0, lane_data[7:0]};
			HALF: ext_data = req_q.is_signed ? {{16{lane_data[15]}}, lane_data[15:0]}
			                                 : {16'd0, lane_data[15:0]};
			default: ext_data = rdata;
		endcase
	end

	// request and load result
	always_ff @(posedge clk) begin
		if (ls_start && !busy) begin
			req_q <= ls_req;
		end
		if (busy && d_done && !req_q.is_store) begin
			load_data <= ext_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			ls_done <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			if (ls_start && !busy) begin
				busy <= 1'b1;
			end else if (busy && d_done) begin
				busy    <= 1'b0;
				ls_done <= 1'b1;
			end
		end
	end

endmodule

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

	// memory geometry
	localparam int MEM_WORDS   = 4096;
	localparam int MEM_INDEX_W = 12;

	// cycles from an accepted read to its data
	localparam int MEM_READ_LATENCY = 2;
	localparam int LAT_CNT_W        = $clog2(MEM_READ_LATENCY + 1);

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	// one mask bit per data bit
	typedef logic [31:0] mask_t;
	typedef logic [MEM_INDEX_W-1:0] mem_index_t;
	typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

	typedef enum logic [1:0] {
		NOP   = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} mem_cmd_e;

	// word command toward the memory
	typedef struct packed {
		mem_cmd_e cmd;
		addr_t    addr;
		word_t    wdata;
		mask_t    wmask;
	} mem_req_t;

endpackage

/* design/mem_interface.sv */
module mem_interface
	import mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	// instruction side
	input  logic     inst_start,
	input  addr_t    i_addr,
	output logic     inst_ready,
	output word_t    inst,
	output logic     inst_valid,

	// data side
	input  mem_req_t d_cmd,
	output logic     d_cmd_ready,
	output word_t    rdata,
	output logic     rdata_valid,
	output logic     d_done,

	// memory side
	output logic     mem_start,
	output mem_req_t mem_req,
	input  logic     mem_ready,
	input  word_t    mem_rdata,
	input  logic     mem_rdata_valid
);

	typedef enum logic [1:0] {
		WAIT_CMD,
		WAIT_MEM_READY,
		WAIT_MEM_READ,
		FINISH
	} state_e;

	state_e   state;
	// current memory access belongs to the fetch
	logic     cmd_is_inst;
	addr_t    i_addr_q;
	mem_req_t d_cmd_q;
	word_t    inst_q;
	logic     inst_valid_q;
	word_t    rdata_q;
	logic     rdata_valid_q;
	logic     d_is_op;
	logic     accept;
	mem_req_t fetch_req;

	assign d_is_op = (d_cmd.cmd != NOP);
	assign accept  = (state == WAIT_CMD) && (inst_start || d_is_op);

	// one shared ready for both sides
	assign inst_ready  = (state == WAIT_CMD);
	assign d_cmd_ready = (state == WAIT_CMD);

	assign inst        = inst_q;
	assign inst_valid  = inst_valid_q;
	assign rdata       = rdata_q;
	assign rdata_valid = rdata_valid_q;

	// completion of a data command, read or write
	assign d_done = (state == FINISH) && !cmd_is_inst;

	// fetch is always a plain word read
	always_comb begin
		fetch_req.cmd   = READ;
		fetch_req.addr  = i_addr_q;
		fetch_req.wdata = '0;
		fetch_req.wmask = '0;
	end

	assign mem_req   = cmd_is_inst ? fetch_req : d_cmd_q;
	assign mem_start = (state == WAIT_MEM_READY) && mem_ready;

	// saved fetch address and read results
	always_ff @(posedge clk) begin
		if (accept) begin
			i_addr_q <= i_addr;
		end
		if (state == WAIT_MEM_READ && mem_rdata_valid) begin
			if (cmd_is_inst) begin
				inst_q <= mem_rdata;
			end else begin
				rdata_q <= mem_rdata;
			end
		end
	end

	// sequencer
	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= WAIT_CMD;
			cmd_is_inst   <= 1'b0;
			d_cmd_q.cmd   <= NOP;
			inst_valid_q  <= 1'b0;
			rdata_valid_q <= 1'b0;
		end else begin
			case (state)
				WAIT_CMD: begin
					if (accept) begin
						// data command saved whole, NOP when only a fetch arrives
						d_cmd_q <= d_cmd;
						// fetch goes first when both arrive
						cmd_is_inst <= inst_start;
						if (inst_start) begin
							inst_valid_q <= 1'b0;
						end
						if (d_is_op) begin
							rdata_valid_q <= 1'b0;
						end
						state <= WAIT_MEM_READY;
					end
				end
				WAIT_MEM_READY: begin
					if (mem_ready) begin
						// write completes once the memory takes it
						if (cmd_is_inst || d_cmd_q.cmd == READ) begin
							state <= WAIT_MEM_READ;
						end else begin
							state <= FINISH;
						end
					end
				end
				WAIT_MEM_READ: begin
					if (mem_rdata_valid) begin
						if (cmd_is_inst) begin
							inst_valid_q <= 1'b1;
						end else begin
							rdata_valid_q <= 1'b1;
						end
						state <= FINISH;
					end
				end
				FINISH: begin
					// pending data command after the fetch
					if (cmd_is_inst && d_cmd_q.cmd != NOP) begin
						cmd_is_inst <= 1'b0;
						state       <= WAIT_MEM_READY;
					end else begin
						state <= WAIT_CMD;
					end
				end
				default: begin
					state <= WAIT_CMD;
				end
			endcase
		end
	end

endmodule

/* design/mem_subsystem_top.sv */
module mem_subsystem_top
	import mem_bus_pkg::*;
	import core_access_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       redirect,
	input  addr_t      redirect_pc,
	input  logic       fetch_next,
	output logic       fetch_busy,
	output fetch_out_t fetch_out,
	output logic       instr_valid,
	input  logic       ls_start,
	input  ls_req_t    ls_req,
	output logic       ls_busy,
	output word_t      load_data,
	output logic       ls_done
);

	// fetch to interface
	logic     inst_start;
	addr_t    i_addr;
	word_t    inst;
	logic     inst_valid;

	// load/store to interface
	mem_req_t d_cmd;
	logic     d_done;
	word_t    rdata;

	// interface to memory
	logic     mem_start;
	mem_req_t mem_req;
	logic     mem_ready;
	word_t    mem_rdata;
	logic     mem_rdata_valid;

	inst_fetch_unit u_inst_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_next  (fetch_next),
		.fetch_busy  (fetch_busy),
		.fetch_out   (fetch_out),
		.instr_valid (instr_valid),
		.inst_start  (inst_start),
		.i_addr      (i_addr),
		.inst_valid  (inst_valid),
		.inst        (inst)
	);

	load_store_unit u_load_store_unit (
		.clk       (clk),
		.rst       (rst),
		.ls_start  (ls_start),
		.ls_req    (ls_req),
		.ls_busy   (ls_busy),
		.load_data (load_data),
		.ls_done   (ls_done),
		.d_cmd     (d_cmd),
		.d_done    (d_done),
		.rdata     (rdata)
	);

	// ready and rdata_valid stay internal, the units track their own busy
	mem_interface u_mem_interface (
		.clk             (clk),
		.rst             (rst),
		.inst_start      (inst_start),
		.i_addr          (i_addr),
		.inst_ready      (),
		.inst            (inst),
		.inst_valid      (inst_valid),
		.d_cmd           (d_cmd),
		.d_cmd_ready     (),
		.rdata           (rdata),
		.rdata_valid     (),
		.d_done          (d_done),
		.mem_start       (mem_start),
		.mem_req         (mem_req),
		.mem_ready       (mem_ready),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid)
	);

	word_memory u_word_memory (
		.clk             (clk),
		.rst             (rst),
		.mem_start       (mem_start),
		.mem_req         (mem_req),
		.mem_ready       (mem_ready),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid)
	);

endmodule

/* design/word_memory.sv */
module word_memory
	import mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     mem_start,
	input  mem_req_t mem_req,
	output logic     mem_ready,
	output word_t    mem_rdata,
	output logic     mem_rdata_valid
);

	word_t      mem [MEM_WORDS];
	word_t      rdata_q;
	mem_index_t idx;
	lat_cnt_t   rd_cnt;
	logic       wr_hold;
	logic       accept;

	// word index from the byte address
	assign idx = mem_req.addr[MEM_INDEX_W+1:2];

	// idle when no read is counting down and no write is settling
	assign mem_ready = (rd_cnt == '0) && !wr_hold;
	assign accept    = mem_start && mem_ready;

	// data shows on the last count of the read
	assign mem_rdata_valid = (rd_cnt == lat_cnt_t'(1));
	assign mem_rdata       = rdata_q;

	// storage array and read data
	always_ff @(posedge clk) begin
		if (accept && mem_req.cmd == WRITE) begin
			// merge new bits under the mask
			mem[idx] <= (mem[idx] & ~mem_req.wmask) | (mem_req.wdata & mem_req.wmask);
		end
		if (accept && mem_req.cmd == READ) begin
			rdata_q <= mem[idx];
		end
	end

	// busy window and read latency
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_cnt  <= '0;
			wr_hold <= 1'b0;
		end else begin
			wr_hold <= 1'b0;
			if (accept && mem_req.cmd == READ) begin
				rd_cnt <= lat_cnt_t'(MEM_READ_LATENCY);
			end else if (rd_cnt != '0) begin
				rd_cnt <= rd_cnt - lat_cnt_t'(1);
			end
			// write takes the accepting edge, then one idle cycle
			if (accept && mem_req.cmd == WRITE) begin
				wr_hold <= 1'b1;
			end
		end
	end

endmodule

/* sources.f */
design/mem_bus_pkg.sv
design/core_access_pkg.sv
design/word_memory.sv
design/mem_interface.sv
design/inst_fetch_unit.sv
design/load_store_unit.sv
design/mem_subsystem_top.sv
verification/mem_subsystem_assert.sv
verification/mem_subsystem_tb.sv

/* verification/mem_cases.txt */
# name op addr size(b/h/w) sign(s/u) data expected, all numbers in hex
# jump/fetch: addr is the expected pc; fetchload: data is the expected instruction
st_w0       store     00000200 w u 12345678 00000000
ld_w0       load      00000200 w u 00000000 12345678
st_w1       store     00000204 w u a5a5a5a5 00000000
st_b1       store     00000205 b u 000000c3 00000000
st_h2       store     00000206 h u 00007e11 00000000
ld_merge1   load      00000204 w u 00000000 7e11c3a5
st_b0       store     00000204 b u 0000ff80 00000000
ld_merge2   load      00000204 w u 00000000 7e11c380
ld_b0s      load      00000204 b s 00000000 ffffff80
ld_b0u      load      00000204 b u 00000000 00000080
ld_b1s      load      00000205 b s 00000000 ffffffc3
ld_b3s      load      00000207 b s 00000000 0000007e
ld_h0s      load      00000204 h s 00000000 ffffc380
ld_h0u      load      00000204 h u 00000000 0000c380
ld_h2s      load      00000206 h s 00000000 00007e11
st_w2       store     00000208 w u 8001f00f 00000000
ld_h2u_neg  load      0000020a h u 00000000 00008001
ld_h2s_neg  load      0000020a h s 00000000 ffff8001
ld_b2u      load      0000020a b u 00000000 00000001
st_i0       store     00000100 w u 00500093 00000000
st_i1       store     00000104 w u 00a00113 00000000
st_i2       store     00000108 w u 002081b3 00000000
st_i3       store     0000010c w u 0000006f 00000000
st_i4       store     00000110 w u 00000013 00000000
jump_0      jump      00000100 w u 00000000 00500093
fetch_1     fetch     00000104 w u 00000000 00a00113
fetch_2     fetch     00000108 w u 00000000 002081b3
fl_word     fetchload 00000200 w u 0000006f 12345678
jump_1      jump      00000104 w u 00000000 00a00113
fetch_busy  fetchbusy 00000108 w u 00000000 002081b3
load_busy   loadbusy  00000204 w u 00000000 7e11c380
fetch_3     fetch     0000010c w u 00000000 0000006f
fl_half     fetchload 00000206 h s 00000013 00007e11

/* verification/mem_subsystem_assert.sv */
module mem_subsystem_assert (
	input logic       clk,
	input logic       rst,
	input logic       mem_start,
	input logic       mem_ready,
	input logic       inst_ready,
	input logic       d_cmd_ready,
	// sequencer state where WAIT_CMD encodes as zero
	input logic [1:0] state
);

	// failed assertions so far
	int unsigned fail_count = 0;

	// memory only started when it is idle
	start_needs_ready: assert property (
		@(posedge clk) disable iff (rst) mem_start |-> mem_ready
	) else begin
		$error("memory start while the memory is busy");
		fail_count++;
	end

	// one shared ready
	readies_equal: assert property (
		@(posedge clk) disable iff (rst) inst_ready == d_cmd_ready
	) else begin
		$error("instruction and data ready differ");
		fail_count++;
	end

	// ready only while waiting for a command
	ready_only_idle: assert property (
		@(posedge clk) disable iff (rst) (state != 2'd0) |-> !(inst_ready || d_cmd_ready)
	) else begin
		$error("ready high while the sequencer is busy");
		fail_count++;
	end

endmodule

bind mem_interface mem_subsystem_assert u_mem_subsystem_assert (
	.clk         (clk),
	.rst         (rst),
	.mem_start   (mem_start),
	.mem_ready   (mem_ready),
	.inst_ready  (inst_ready),
	.d_cmd_ready (d_cmd_ready),
	.state       (state)
);

/* verification/mem_subsystem_tb.sv */
module mem_subsystem_tb
	import mem_bus_pkg::*;
	import core_access_pkg::*;
();

	// numeric fields of one case line
	typedef struct packed {
		addr_t        addr;
		access_size_e size;
		logic         is_signed;
		word_t        data;
		word_t        expected;
	} case_t;

	logic       clk;
	logic       rst;
	logic       redirect;
	addr_t      redirect_pc;
	logic       fetch_next;
	logic       fetch_busy;
	fetch_out_t fetch_out;
	logic       instr_valid;
	logic       ls_start;
	ls_req_t    ls_req;
	logic       ls_busy;
	word_t      load_data;
	logic       ls_done;

	case_t case_q[$];
	string name_q[$];
	string op_q[$];
	int    n_pass;
	int    n_fail;
	// mismatches in the running test
	int    n_mism;
	int    bg_words;
	logic  loaded;

	mem_subsystem_top u_mem_subsystem_top (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_next  (fetch_next),
		.fetch_busy  (fetch_busy),
		.fetch_out   (fetch_out),
		.instr_valid (instr_valid),
		.ls_start    (ls_start),
		.ls_req      (ls_req),
		.ls_busy     (ls_busy),
		.load_data   (load_data),
		.ls_done     (ls_done)
	);

	// 20 unit period
	always #10 clk = ~clk;

	task automatic check(input string what, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %08h actual %08h", what, expected, actual);
			n_mism++;
		end
	endtask

	// one line per finished test
	task automatic report_test(input string nm);
		if (n_mism == 0) begin
			n_pass++;
			$display("[ OK ] %s", nm);
		end else begin
			n_fail++;
			$display("test %s failed with %0d mismatches", nm, n_mism);
		end
	endtask

	function automatic ls_req_t make_req(input logic is_store, input case_t c);
		ls_req_t r;
		r.is_store  = is_store;
		r.size      = c.size;
		r.is_signed = c.is_signed;
		r.addr      = c.addr;
		r.data      = c.data;
		return r;
	endfunction

	// one-cycle request pulse on either port
	task automatic pulse_request(input logic do_fetch, input logic do_ls, input ls_req_t r);
		@(posedge clk);
		fetch_next <= do_fetch;
		ls_start   <= do_ls;
		ls_req     <= r;
		@(posedge clk);
		fetch_next <= 1'b0;
		ls_start   <= 1'b0;
	endtask

	task automatic redirect_to(input addr_t pc);
		@(posedge clk);
		redirect    <= 1'b1;
		redirect_pc <= pc;
		@(posedge clk);
		redirect <= 1'b0;
	endtask

	// outputs sampled at the edge, before the DUT updates them
	task automatic wait_ls(output word_t data);
		@(posedge clk);
		while (!ls_done) @(posedge clk);
		data = load_data;
	endtask

	task automatic wait_fetch(output fetch_out_t f);
		@(posedge clk);
		while (!instr_valid) @(posedge clk);
		f = fetch_out;
	endtask

	// result pulses that nobody asked for
	task automatic count_extra(input int cycles, output int extra);
		extra = 0;
		repeat (cycles) begin
			@(posedge clk);
			if (ls_done || instr_valid) extra++;
		end
	endtask

	// strobes and busy flags all low once reset is released
	task automatic check_reset_outputs();
		n_mism = 0;
		@(posedge clk);
		check("reset.instr_valid", 32'd0, word_t'(instr_valid));
		check("reset.ls_done", 32'd0, word_t'(ls_done));
		check("reset.fetch_busy", 32'd0, word_t'(fetch_busy));
		check("reset.ls_busy", 32'd0, word_t'(ls_busy));
		report_test("reset");
	endtask

	task automatic read_cases();
		int    fd;
		int    code;
		int    ch;
		string tok;
		string op;
		string sz;
		string sg;
		addr_t addr;
		word_t data;
		word_t expected;
		case_t c;
		fd = $fopen("verification/mem_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/mem_cases.txt, no cases were run");
			n_fail++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.getc(0) == "#") begin
					// drop the rest of a comment line
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1) ch = $fgetc(fd);
				end else begin
					code = $fscanf(fd, "%s %h %s %s %h %h", op, addr, sz, sg, data, expected);
					if (code != 6) begin
						$display("case %s is malformed and was skipped", tok);
						n_fail++;
					end else begin
						c.addr      = addr;
						c.size      = (sz == "b") ? BYTE : (sz == "h") ? HALF : WORD;
						c.is_signed = (sg == "s");
						c.data      = data;
						c.expected  = expected;
						case_q.push_back(c);
						name_q.push_back(tok);
						op_q.push_back(op);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// random words away from the case addresses, then read back
	task automatic run_background();
		word_t   bg_data[$];
		case_t   c;
		word_t   d;
		int      k;
		n_mism = 0;
		for (k = 0; k < bg_words; k++) begin
			c          = '0;
			c.addr     = addr_t'(32'h300 + 4 * k);
			c.size     = WORD;
			c.data     = $urandom();
			bg_data.push_back(c.data);
			pulse_request(1'b0, 1'b1, make_req(1'b1, c));
			wait_ls(d);
		end
		for (k = 0; k < bg_words; k++) begin
			c      = '0;
			c.addr = addr_t'(32'h300 + 4 * k);
			c.size = WORD;
			pulse_request(1'b0, 1'b1, make_req(1'b0, c));
			wait_ls(d);
			check($sformatf("background[%0d]", k), bg_data[k], d);
		end
		report_test("background");
	endtask

	task automatic run_case(input int i);
		case_t      c;
		string      nm;
		string      op;
		ls_req_t    r;
		fetch_out_t f;
		word_t      d;
		int         cyc;
		int         i_cyc;
		int         l_cyc;
		int         extra;
		c      = case_q[i];
		nm     = name_q[i];
		op     = op_q[i];
		n_mism = 0;
		r      = make_req(op == "store", c);
		if (op == "store") begin
			pulse_request(1'b0, 1'b1, r);
			wait_ls(d);
		end else if (op == "load") begin
			pulse_request(1'b0, 1'b1, r);
			wait_ls(d);
			check(nm, c.expected, d);
		end else if (op == "jump" || op == "fetch") begin
			if (op == "jump") redirect_to(c.addr);
			pulse_request(1'b1, 1'b0, r);
			wait_fetch(f);
			check({nm, ".pc"}, c.addr, f.pc);
			check({nm, ".instr"}, c.expected, f.instr);
		end else if (op == "loadbusy") begin
			pulse_request(1'b0, 1'b1, r);
			// second load lands while the unit is busy
			r.addr = r.addr + addr_t'(4);
			pulse_request(1'b0, 1'b1, r);
			check({nm, ".busy"}, 32'd1, word_t'(ls_busy));
			wait_ls(d);
			check(nm, c.expected, d);
			check({nm, ".idle"}, 32'd0, word_t'(ls_busy));
			count_extra(8, extra);
			check({nm, ".extra"}, 32'd0, word_t'(extra));
		end else if (op == "fetchbusy") begin
			pulse_request(1'b1, 1'b0, r);
			pulse_request(1'b1, 1'b0, r);
			check({nm, ".busy"}, 32'd1, word_t'(fetch_busy));
			wait_fetch(f);
			check({nm, ".pc"}, c.addr, f.pc);
			check({nm, ".instr"}, c.expected, f.instr);
			check({nm, ".idle"}, 32'd0, word_t'(fetch_busy));
			count_extra(8, extra);
			check({nm, ".extra"}, 32'd0, word_t'(extra));
		end else if (op == "fetchload") begin
			pulse_request(1'b1, 1'b1, r);
			cyc   = 0;
			i_cyc = -1;
			l_cyc = -1;
			while (i_cyc < 0 || l_cyc < 0) begin
				@(posedge clk);
				cyc++;
				if (instr_valid && i_cyc < 0) begin
					i_cyc = cyc;
					f     = fetch_out;
				end
				if (ls_done && l_cyc < 0) begin
					l_cyc = cyc;
					d     = load_data;
				end
			end
			check({nm, ".instr"}, c.data, f.instr);
			check({nm, ".load"}, c.expected, d);
			// fetch is served first
			check({nm, ".order"}, 32'd1, word_t'(i_cyc <= l_cyc));
		end else begin
			$display("case %s has an unknown operation %s", nm, op);
			n_mism++;
		end
		report_test(nm);
	endtask

	initial begin
		int i;
		int n_assert;
		clk         = 1'b0;
		rst         = 1'b1;
		redirect    = 1'b0;
		redirect_pc = '0;
		fetch_next  = 1'b0;
		ls_start    = 1'b0;
		ls_req      = '0;
		n_pass      = 0;
		n_fail      = 0;
		n_mism      = 0;
		bg_words    = 8;
		loaded      = 1'b0;
		void'($urandom(32'hae5ea48d));
		read_cases();
		loaded = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		check_reset_outputs();
		run_background();
		for (i = 0; i < case_q.size(); i++) run_case(i);
		n_assert = u_mem_subsystem_top.u_mem_interface.u_mem_subsystem_assert.fail_count;
		$display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
			n_pass + n_fail, n_pass, n_fail, n_assert);
		if (n_fail == 0 && n_assert == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog allows 50 cycles per operation plus reset
	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(case_q.size() + 2 * bg_words + 10) * 50 * 20;
		#(limit);
		$display("timeout: the tests did not finish within %0t time units", limit);
		$display(">>> FAIL");
		$finish;
	end

endmodule
